/* axis_fir_lowpass.sv */
`timescale 1ns/1ps
`include "fir_settings.svh"

module axis_fir_lowpass (
        input  logic               s00_axis_aclk,
        input  logic               rst_n,

        // input stream
        input  logic               s00_axis_tvalid,
        input  fir_pkg::bus_word_t s00_axis_tdata,
        input  logic               s00_axis_tlast,
        output logic               s00_axis_tready,

        // filtered output stream
        input  logic               m00_axis_tready,
        output logic               m00_axis_tvalid,
        output fir_pkg::bus_word_t m00_axis_tdata,
        output logic               m00_axis_tlast
);
        import fir_pkg::*;

        sample_t sample;
        acc_t    result;
        logic    result_last;
        logic    accept;

        // lower half of the input word carries nothing
        assign sample = s00_axis_tdata[`FIR_SAMPLE_MSB -: `FIR_SAMPLE_WIDTH];

        fir_tap_chain i_fir_tap_chain (
                .s00_axis_aclk (s00_axis_aclk),
                .rst_n         (rst_n),
                .accept        (accept),
                .sample        (sample),
                .sample_last   (s00_axis_tlast),
                .result        (result),
                .result_last   (result_last)
        );

        // handshake decided here, the chain only steps on accept
        fir_out_stage i_fir_out_stage (
                .s00_axis_aclk   (s00_axis_aclk),
                .rst_n           (rst_n),
                .in_valid        (s00_axis_tvalid),
                .result          (result),
                .result_last     (result_last),
                .m00_axis_tready (m00_axis_tready),
                .in_ready        (s00_axis_tready),
                .accept          (accept),
                .m00_axis_tvalid (m00_axis_tvalid),
                .m00_axis_tdata  (m00_axis_tdata),
                .m00_axis_tlast  (m00_axis_tlast)
        );

endmodule

/* axis_fir_lowpass_properties.sv */
`timescale 1ns/1ps

module axis_fir_lowpass_properties (
        input logic               s00_axis_aclk,
        input logic               rst_n,
        input logic               s00_axis_tvalid,
        input logic               s00_axis_tready,
        input logic               m00_axis_tvalid,
        input logic               m00_axis_tready,
        input fir_pkg::bus_word_t m00_axis_tdata,
        input logic               m00_axis_tlast
);
        logic out_held;

        // output word waiting on the sink
        assign out_held = m00_axis_tvalid && !m00_axis_tready;

        held_word_stable: assert property (
                @(posedge s00_axis_aclk) disable iff (!rst_n)
                out_held |=> m00_axis_tvalid && $stable(m00_axis_tdata)
                        && $stable(m00_axis_tlast)
        ) else $error("output word or tlast changed while the sink stalled");

        no_valid_in_reset: assert property (
                @(posedge s00_axis_aclk)
                !rst_n |-> !m00_axis_tvalid
        ) else $error("output valid high while reset is applied");

        // one-entry stage, so a held word blocks the input side
        no_accept_when_held: assert property (
                @(posedge s00_axis_aclk) disable iff (!rst_n)
                out_held |-> !(s00_axis_tvalid && s00_axis_tready)
        ) else $error("input sample accepted while the output word is held");

endmodule

bind axis_fir_lowpass axis_fir_lowpass_properties i_axis_fir_lowpass_properties (
        .s00_axis_aclk   (s00_axis_aclk),
        .rst_n           (rst_n),
        .s00_axis_tvalid (s00_axis_tvalid),
        .s00_axis_tready (s00_axis_tready),
        .m00_axis_tvalid (m00_axis_tvalid),
        .m00_axis_tready (m00_axis_tready),
        .m00_axis_tdata  (m00_axis_tdata),
        .m00_axis_tlast  (m00_axis_tlast)
);

/* build.f */
+incdir+.
fir_pkg.sv
fir_tap_chain.sv
fir_out_stage.sv
axis_fir_lowpass.sv
tb_clock_gen.sv
axis_fir_lowpass_properties.sv
tb_axis_fir_lowpass.sv

/* fir_out_stage.sv */
`timescale 1ns/1ps

module fir_out_stage (
        input  logic               s00_axis_aclk,
        input  logic               rst_n,
        input  logic               in_valid,
        input  fir_pkg::acc_t      result,
        input  logic               result_last,
        input  logic               m00_axis_tready,
        output logic               in_ready,
        output logic               accept,
        output logic               m00_axis_tvalid,
        output fir_pkg::bus_word_t m00_axis_tdata,
        output logic               m00_axis_tlast
);
        import fir_pkg::*;

        logic deliver;

        // room when the register is empty or is being emptied this cycle
        assign in_ready = !m00_axis_tvalid || m00_axis_tready;
        assign accept   = in_valid && in_ready;
        assign deliver  = m00_axis_tvalid && m00_axis_tready;

        always_ff @(posedge s00_axis_aclk or negedge rst_n) begin
                if (!rst_n) begin
                        m00_axis_tvalid <= 1'b0;
                end else if (accept) begin
                        m00_axis_tvalid <= 1'b1;
                end else if (deliver) begin
                        m00_axis_tvalid <= 1'b0;
                end
        end

        // word and tlast only change on accept, so they hold while stalled
        always_ff @(posedge s00_axis_aclk) begin
                if (accept) begin
                        m00_axis_tdata <= bus_word_t'(result);
                        m00_axis_tlast <= result_last;
                end
        end

endmodule

/* fir_pkg.sv */
`include "fir_settings.svh"

package fir_pkg;

        // raw stream data word
        typedef logic [`FIR_BUS_WIDTH-1:0] bus_word_t;

        // signed sample taken from the upper half of a word
        typedef logic signed [`FIR_SAMPLE_WIDTH-1:0] sample_t;

        typedef logic signed [`FIR_COEFF_WIDTH-1:0] coeff_t;

        // partial sum in the chain, also the width of one output word
        typedef logic signed [`FIR_ACC_WIDTH-1:0] acc_t;

        typedef coeff_t coeff_table_t [`FIR_NUM_TAPS];

        // symmetric low-pass taps, index 0 multiplies the newest sample
        localparam coeff_table_t FIR_COEFFS = '{
                -16'sd12,
                16'sd0,
                16'sd31,
                16'sd0,
                -16'sd78,
                16'sd0,
                16'sd307,
                16'sd512,
                16'sd307,
                16'sd0,
                -16'sd78,
                16'sd0,
                16'sd31,
                16'sd0,
                -16'sd12
        };

endpackage

/* fir_settings.svh */
`ifndef FIR_SETTINGS_SVH
`define FIR_SETTINGS_SVH

// number of filter taps, the table in fir_pkg has this many entries
`define FIR_NUM_TAPS 15

// stream word width on both sides
`define FIR_BUS_WIDTH 64

// input sample sits in the upper half of the stream word
`define FIR_SAMPLE_WIDTH 32
`define FIR_SAMPLE_MSB 63

`define FIR_COEFF_WIDTH 16

// partial sums and the filter result
`define FIR_ACC_WIDTH 64

`endif

/* fir_tap_chain.sv */
`timescale 1ns/1ps
`include "fir_settings.svh"

module fir_tap_chain (
        input  logic             s00_axis_aclk,
        input  logic             rst_n,
        // one sample taken in this cycle
        input  logic             accept,
        input  fir_pkg::sample_t sample,
        input  logic             sample_last,
        output fir_pkg::acc_t    result,
        output logic             result_last
);
        import fir_pkg::*;

        // partial-sum registers between the taps
        localparam int NUM_REGS = `FIR_NUM_TAPS - 1;

        acc_t sample_ext;
        acc_t prod [`FIR_NUM_TAPS];
        acc_t chain [NUM_REGS];

        // sign extend once, every product is formed at full accumulator width
        assign sample_ext = acc_t'(sample);

        always_comb begin
                for (int k = 0; k < `FIR_NUM_TAPS; k++) begin
                        prod[k] = sample_ext * acc_t'(FIR_COEFFS[k]);
                end
        end

        // transposed form
        // chain[i] holds the contribution of older samples to the next output
        // and moves one step towards chain[0] per accepted sample
        always_ff @(posedge s00_axis_aclk or negedge rst_n) begin
                if (!rst_n) begin
                        for (int i = 0; i < NUM_REGS; i++) begin
                                chain[i] <= '0;
                        end
                end else if (accept) begin
                        for (int i = 0; i < NUM_REGS; i++) begin
                                if (i == NUM_REGS - 1) begin
                                        // oldest tap has nothing above it
                                        chain[i] <= prod[i + 1];
                                end else begin
                                        chain[i] <= prod[i + 1] + chain[i + 1];
                                end
                        end
                end
        end

        // output for the sample currently on the input
        assign result = prod[0] + chain[0];

        // tlast belongs to the same sample as result
        assign result_last = sample_last;

endmodule

/* tb_axis_fir_lowpass.sv */
`timescale 1ns/1ps
`include "fir_settings.svh"

module tb_axis_fir_lowpass;
        import fir_pkg::*;

        localparam int RESET_CYCLES  = 8;
        localparam int CLK_PERIOD_NS = 40;
        localparam int MAX_GAP       = 2;
        localparam int MAX_STALL     = 7;
        localparam int IMPULSE_ROWS  = 21;
        localparam int STEADY_ROWS   = 40;
        localparam int STALL_ROWS    = 40;
        localparam int RESTART_ROWS  = 30;

        typedef struct {
                sample_t     sample;
                logic [31:0] low_half;
                logic        last;
                int          gap;
                logic [7:0]  stall;
                logic        reset_before;
        } stim_row_t;

        logic        s00_axis_aclk;
        logic        rst_n;
        logic        s00_axis_tvalid;
        bus_word_t   s00_axis_tdata;
        logic        s00_axis_tlast;
        logic        s00_axis_tready;
        logic        m00_axis_tready;
        logic        m00_axis_tvalid;
        bus_word_t   m00_axis_tdata;
        logic        m00_axis_tlast;

        stim_row_t   stim_table[$];
        sample_t     history[`FIR_NUM_TAPS];
        acc_t        exp_data_q[$];
        logic        exp_last_q[$];
        logic [31:0] rng_state;
        int unsigned cycle_count;
        int unsigned out_count;
        logic        table_ready;
        longint      watchdog_ns;

        tb_clock_gen i_tb_clock_gen (
                .clk (s00_axis_aclk)
        );

        axis_fir_lowpass i_axis_fir_lowpass (
                .s00_axis_aclk   (s00_axis_aclk),
                .rst_n           (rst_n),
                .s00_axis_tvalid (s00_axis_tvalid),
                .s00_axis_tdata  (s00_axis_tdata),
                .s00_axis_tlast  (s00_axis_tlast),
                .s00_axis_tready (s00_axis_tready),
                .m00_axis_tready (m00_axis_tready),
                .m00_axis_tvalid (m00_axis_tvalid),
                .m00_axis_tdata  (m00_axis_tdata),
                .m00_axis_tlast  (m00_axis_tlast)
        );

        function automatic logic [31:0] xorshift32(input logic [31:0] x);
                logic [31:0] y;
                y = x ^ (x << 13);
                y = y ^ (y >> 17);
                y = y ^ (y << 5);
                return y;
        endfunction

        task automatic abort_run();
                $display("Testbench failed");
                $fatal(1, "stopped at the first error");
        endtask

        task automatic report_error(input string msg);
                $display("error at %0t ns: %s", $time, msg);
                abort_run();
        endtask

        task automatic check_result(input acc_t got, input acc_t exp, input int unsigned idx);
                if (got !== exp) begin
                        $display("mismatch at %0t ns: output %0d data got %0d expected %0d",
                                 $time, idx, got, exp);
                        abort_run();
                end
        endtask

        task automatic check_last(input logic got, input logic exp, input int unsigned idx);
                if (got !== exp) begin
                        $display("mismatch at %0t ns: output %0d tlast got %b expected %b",
                                 $time, idx, got, exp);
                        abort_run();
                end
        endtask

        // samples before reset count as zero
        task automatic clear_model();
                for (int k = 0; k < `FIR_NUM_TAPS; k++) begin
                        history[k] = '0;
                end
                exp_data_q.delete();
                exp_last_q.delete();
        endtask

        // y[n] = sum of coeff[k] * x[n-k]
        task automatic model_accept(input sample_t s, input logic last);
                acc_t sum;
                for (int k = `FIR_NUM_TAPS - 1; k > 0; k--) begin
                        history[k] = history[k - 1];
                end
                history[0] = s;
                sum = '0;
                for (int k = 0; k < `FIR_NUM_TAPS; k++) begin
                        sum = sum + acc_t'(history[k]) * acc_t'(FIR_COEFFS[k]);
                end
                exp_data_q.push_back(sum);
                exp_last_q.push_back(last);
        endtask

        task automatic add_random_rows(input int count, input logic with_stalls,
                                       input logic restart);
                stim_row_t row;
                for (int i = 0; i < count; i++) begin
                        rng_state = xorshift32(rng_state);
                        row.sample = sample_t'(rng_state);
                        rng_state = xorshift32(rng_state);
                        row.low_half = rng_state;
                        rng_state = xorshift32(rng_state);
                        if (with_stalls) begin
                                row.gap = rng_state % (MAX_GAP + 1);
                                // bit 7 clear keeps the sink ready once every 8 cycles
                                row.stall = rng_state[15:8] & 8'h7f;
                                row.last = rng_state[20];
                        end else begin
                                row.gap = 0;
                                row.stall = 8'h00;
                                row.last = (i % 8 == 7);
                        end
                        row.reset_before = restart && (i == 0);
                        stim_table.push_back(row);
                end
        endtask

        task automatic build_table();
                stim_row_t row;
                // impulse then zeros, the outputs walk through the coefficient table
                for (int i = 0; i < IMPULSE_ROWS; i++) begin
                        rng_state = xorshift32(rng_state);
                        row.sample = (i == 0) ? sample_t'(1) : sample_t'(0);
                        row.low_half = rng_state;
                        row.last = (i == IMPULSE_ROWS - 1);
                        row.gap = 0;
                        row.stall = 8'h00;
                        row.reset_before = 1'b0;
                        stim_table.push_back(row);
                end
                add_random_rows(STEADY_ROWS, 1'b0, 1'b0);
                add_random_rows(STALL_ROWS, 1'b1, 1'b0);
                add_random_rows(RESTART_ROWS, 1'b1, 1'b1);
        endtask

        // one clock: drive on the falling edge, look at the handshakes once settled
        task automatic step(input logic valid, input sample_t sample,
                            input logic [31:0] low_half, input logic last,
                            input logic [7:0] stall, output logic accepted);
                @(negedge s00_axis_aclk);
                s00_axis_tvalid = valid;
                s00_axis_tdata = {sample, low_half};
                s00_axis_tlast = last;
                m00_axis_tready = !stall[cycle_count % 8];
                #1;
                if (m00_axis_tvalid && m00_axis_tready) begin
                        if (exp_data_q.size() == 0) begin
                                report_error("output word delivered with no sample to match it");
                        end
                        check_result(acc_t'(m00_axis_tdata), exp_data_q[0], out_count);
                        check_last(m00_axis_tlast, exp_last_q[0], out_count);
                        void'(exp_data_q.pop_front());
                        void'(exp_last_q.pop_front());
                        out_count++;
                end
                accepted = valid && s00_axis_tready;
                if (accepted) begin
                        model_accept(sample, last);
                end
                cycle_count++;
        endtask

        task automatic apply_reset();
                @(negedge s00_axis_aclk);
                rst_n = 1'b0;
                s00_axis_tvalid = 1'b0;
                s00_axis_tlast = 1'b0;
                m00_axis_tready = 1'b1;
                repeat (RESET_CYCLES) @(negedge s00_axis_aclk);
                if (m00_axis_tvalid !== 1'b0) begin
                        report_error("output valid is not low while reset is applied");
                end
                // words still in flight are lost with the reset
                clear_model();
                rst_n = 1'b1;
                #1;
                if (s00_axis_tready !== 1'b1) begin
                        report_error("input ready is not high after reset");
                end
        endtask

        initial begin
                logic accepted;
                int   tries;
                rst_n = 1'b0;
                s00_axis_tvalid = 1'b0;
                s00_axis_tdata = '0;
                s00_axis_tlast = 1'b0;
                m00_axis_tready = 1'b0;
                rng_state = 32'h97c8;
                cycle_count = 0;
                out_count = 0;
                table_ready = 1'b0;
                clear_model();
                build_table();
                watchdog_ns = longint'(stim_table.size()) * (MAX_GAP + MAX_STALL + 4)
                              * CLK_PERIOD_NS + 4 * RESET_CYCLES * CLK_PERIOD_NS;
                table_ready = 1'b1;

                repeat (RESET_CYCLES) @(negedge s00_axis_aclk);
                if (m00_axis_tvalid !== 1'b0) begin
                        report_error("output valid is not low during the first reset");
                end
                rst_n = 1'b1;

                foreach (stim_table[i]) begin
                        if (stim_table[i].reset_before) begin
                                apply_reset();
                        end
                        for (int g = 0; g < stim_table[i].gap; g++) begin
                                step(1'b0, '0, '0, 1'b0, stim_table[i].stall, accepted);
                        end
                        tries = 0;
                        accepted = 1'b0;
                        while (!accepted) begin
                                step(1'b1, stim_table[i].sample, stim_table[i].low_half,
                                     stim_table[i].last, stim_table[i].stall, accepted);
                                tries++;
                        end
                        // with the sink always ready every sample goes in at once
                        if (stim_table[i].stall == 8'h00 && tries != 1) begin
                                report_error("sample not accepted at once with the sink ready");
                        end
                end

                while (exp_data_q.size() != 0) begin
                        step(1'b0, '0, '0, 1'b0, 8'h00, accepted);
                end
                repeat (4) begin
                        step(1'b0, '0, '0, 1'b0, 8'h00, accepted);
                end

                $display("Testbench passed");
                $finish;
        end

        initial begin
                wait (table_ready === 1'b1);
                #(watchdog_ns);
                $display("timeout: the run did not finish within %0d ns", watchdog_ns);
                $display("Testbench failed");
                $fatal(1, "watchdog expired");
        end

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
        output logic clk
);
        // 40 ns period
        localparam int HALF_PERIOD_NS = 20;

        initial begin
                clk = 1'b0;
                forever #(HALF_PERIOD_NS) clk = ~clk;
        end

endmodule
